//--- src.f
hw/exu_pkg.sv
hw/exu_alu.sv
hw/exu_bypass.sv
hw/exu_stage.sv
hw/exu_csr.sv
hw/exu_top.sv
testbench/exu_assertions.sv
testbench/tb_exu.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_exu
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_exu.sv
`timescale 1ns/1ns

module tb_exu;

    localparam int CLK_PERIOD = 4;
    localparam int DEPTH = 4;
    localparam int N_RAND = 40;
    localparam int N_FIXED = 40;
    localparam int CYC_PER_INSTR = 12;
    localparam int TIMEOUT_NS = (N_RAND + N_FIXED) * CYC_PER_INSTR * CLK_PERIOD + 200;

    typedef struct packed {
        logic valid;
        logic fence;
        logic chk_res;
        exu_pkg::xlen_t result;
        logic redir;
        exu_pkg::xlen_t rpc;
    } exp_t;

    logic clk = 1'b0;
    logic rst;
    logic dec_valid;
    exu_pkg::dec_to_exe_t dec;
    logic lsu_ready;
    logic load_done;
    exu_pkg::xlen_t load_data;
    logic pc_update;
    logic exu_ready;
    logic exe_valid;
    exu_pkg::exe_to_mem_t exe_out;
    logic fence_i;
    logic redirect_valid;
    exu_pkg::xlen_t redirect_pc;

    integer seed = 32'hd279;
    int errors = 0;
    int checks = 0;
    int test_start = 0;
    exp_t exp_q[$];
    exp_t cmp_e;

    // Reference architectural state
    exu_pkg::xlen_t regs[16];
    exu_pkg::reg_idx_t recent[$];
    exu_pkg::xlen_t m_mstatus = 0;
    exu_pkg::xlen_t m_mtvec = 0;
    exu_pkg::xlen_t m_mepc = 0;
    exu_pkg::xlen_t m_mcause = 0;
    logic redir_on = 1'b0;
    exu_pkg::xlen_t redir_pc_m = 0;
    exu_pkg::xlen_t next_pc = 32'h1000;

    exu_top #(
        .BYPASS_DEPTH(DEPTH)
    ) dut (
        .clk(clk), .rst(rst), .dec_valid(dec_valid), .dec(dec),
        .lsu_ready(lsu_ready), .load_done(load_done), .load_data(load_data),
        .pc_update(pc_update), .exu_ready(exu_ready), .exe_valid(exe_valid),
        .exe_out(exe_out), .fence_i(fence_i), .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic exu_pkg::xlen_t ref_alu(exu_pkg::alu_op_e op, exu_pkg::xlen_t a,
                                               exu_pkg::xlen_t b);
        case (op)
            exu_pkg::ALU_SUB:    return a - b;
            exu_pkg::ALU_AND:    return a & b;
            exu_pkg::ALU_OR:     return a | b;
            exu_pkg::ALU_XOR:    return a ^ b;
            exu_pkg::ALU_SLL:    return a << b[4:0];
            exu_pkg::ALU_SRL:    return a >> b[4:0];
            exu_pkg::ALU_SRA:    return $signed(a) >>> b[4:0];
            exu_pkg::ALU_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exu_pkg::ALU_SLTU:   return (a < b) ? 32'd1 : 32'd0;
            exu_pkg::ALU_PASS_B: return b;
            exu_pkg::ALU_JUMP:   return (a + b) & 32'hffff_fffe;
            default:             return a + b;
        endcase
    endfunction

    function automatic logic ref_cond(exu_pkg::alu_op_e op, exu_pkg::xlen_t a,
                                      exu_pkg::xlen_t b);
        case (op)
            exu_pkg::ALU_BEQ:  return a == b;
            exu_pkg::ALU_BNE:  return a != b;
            exu_pkg::ALU_BLT:  return $signed(a) < $signed(b);
            exu_pkg::ALU_BGE:  return $signed(a) >= $signed(b);
            exu_pkg::ALU_BLTU: return a < b;
            exu_pkg::ALU_BGEU: return a >= b;
            exu_pkg::ALU_JUMP: return 1'b1;
            default:           return 1'b0;
        endcase
    endfunction

    function automatic exu_pkg::xlen_t csr_read(exu_pkg::csr_addr_t addr);
        case (addr)
            exu_pkg::MSTATUS: return m_mstatus;
            exu_pkg::MTVEC:   return m_mtvec;
            exu_pkg::MEPC:    return m_mepc;
            exu_pkg::MCAUSE:  return m_mcause;
            default:          return 32'd0;
        endcase
    endfunction

    task automatic csr_write(input exu_pkg::csr_addr_t addr, input exu_pkg::xlen_t val);
        case (addr)
            exu_pkg::MSTATUS: m_mstatus = val;
            exu_pkg::MTVEC:   m_mtvec = val;
            exu_pkg::MEPC:    m_mepc = val;
            exu_pkg::MCAUSE:  m_mcause = val;
            default: ;
        endcase
    endtask

    // Register file value that is stale while the writer is still in the forwarding queue
    function automatic exu_pkg::xlen_t src_value(exu_pkg::reg_idx_t rs);
        if (rs == 0) begin
            return 32'd0;
        end
        foreach (recent[i]) begin
            if (recent[i] == rs) begin
                return regs[rs] ^ 32'h5a5a_0f0f;
            end
        end
        return regs[rs];
    endfunction

    function automatic exu_pkg::dec_to_exe_t make_op(exu_pkg::alu_op_e op,
            exu_pkg::reg_idx_t rd, exu_pkg::reg_idx_t rs1, exu_pkg::reg_idx_t rs2,
            exu_pkg::xlen_t imm, logic use_imm);
        exu_pkg::dec_to_exe_t d;
        d = '0;
        d.alu_op = op;
        d.rd = rd;
        d.rs1 = rs1;
        d.rs2 = rs2;
        d.imm = imm;
        d.src2_is_imm = use_imm;
        d.gpr_we = 1'b1;
        return d;
    endfunction

    task automatic check(input string name, input exu_pkg::xlen_t got,
                         input exu_pkg::xlen_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    // Called on a falling edge; returns on the falling edge after acceptance
    task automatic send(input exu_pkg::dec_to_exe_t d);
        exp_t e;
        exu_pkg::xlen_t s1;
        exu_pkg::xlen_t s2;
        exu_pkg::xlen_t a;
        exu_pkg::xlen_t b;
        exu_pkg::xlen_t old;
        exu_pkg::xlen_t tgt;
        logic tk;
        d.pc = next_pc;
        next_pc = next_pc + 4;
        d.src1_r = src_value(d.rs1);
        d.src2_r = src_value(d.rs2);
        s1 = (d.rs1 == 0) ? 32'd0 : regs[d.rs1];
        s2 = (d.rs2 == 0) ? 32'd0 : regs[d.rs2];
        a = d.src1_is_pc ? d.pc : s1;
        b = d.src2_is_imm ? d.imm : s2;
        old = csr_read(d.csr_addr);
        e.valid = !redir_on;
        e.fence = !redir_on && d.is_fence_i;
        e.chk_res = d.gpr_we;
        e.result = d.is_jump ? d.pc + 4 : (d.csr_rw | d.csr_rs) ? old : ref_alu(d.alu_op, a, b);
        e.redir = redir_on;
        e.rpc = redir_pc_m;
        if (!redir_on) begin
            tk = d.ecall | d.mret | ((d.is_jump | d.is_branch) & ref_cond(d.alu_op, s1, s2));
            tgt = (d.ecall | d.mret) ? old : ref_alu(d.alu_op, a, b);
            if (tk && tgt != d.pc + 4) begin
                redir_on = 1'b1;
                redir_pc_m = tgt;
                e.redir = 1'b1;
                e.rpc = tgt;
            end
            if (d.gpr_we) begin
                if (d.rd != 0) begin
                    regs[d.rd] = e.result;
                end
                recent.push_front(d.rd);
                if (recent.size() > DEPTH) begin
                    void'(recent.pop_back());
                end
            end
            if (d.csr_rw) csr_write(d.csr_addr, s1);
            if (d.csr_rs) csr_write(d.csr_addr, s1 | old);
            if (d.ecall) begin
                m_mepc = d.pc;
                m_mcause = 32'd11;
            end
        end
        exp_q.push_back(e);
        dec = d;
        dec_valid = 1'b1;
        do @(posedge clk); while (!exu_ready);
        @(negedge clk);
        dec_valid = 1'b0;
    endtask

    task automatic update_pc();
        pc_update = 1'b1;
        @(negedge clk);
        pc_update = 1'b0;
        redir_on = 1'b0;
        @(negedge clk);
        check("redirect_valid", {31'd0, redirect_valid}, 32'd0);
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    // Compares each accepted instruction one cycle later
    always @(posedge clk) begin
        if (!rst && dec_valid && exu_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Accepted an instruction that the testbench did not send");
            end else begin
                cmp_e = exp_q.pop_front();
                @(negedge clk);
                check("exe_valid", {31'd0, exe_valid}, {31'd0, cmp_e.valid});
                check("fence_i", {31'd0, fence_i}, {31'd0, cmp_e.fence});
                if (cmp_e.valid && cmp_e.chk_res) begin
                    check("exe_out.result", exe_out.result, cmp_e.result);
                end
                check("redirect_valid", {31'd0, redirect_valid}, {31'd0, cmp_e.redir});
                if (cmp_e.redir) begin
                    check("redirect_pc", redirect_pc, cmp_e.rpc);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        exu_pkg::dec_to_exe_t d;
        exu_pkg::xlen_t snap_res;
        logic snap_valid;
        logic [31:0] r;
        rst = 1'b1;
        dec_valid = 1'b0;
        dec = '0;
        lsu_ready = 1'b1;
        load_done = 1'b0;
        load_data = '0;
        pc_update = 1'b0;
        foreach (regs[i]) regs[i] = 32'd0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < N_RAND; n++) begin
            r = $random(seed);
            d = make_op(exu_pkg::alu_op_e'(5'(r[15:0] % 11)), (r[19:16] == 0) ? 4'd1 : r[19:16],
                        r[23:20], r[27:24], 32'($random(seed)), r[28]);
            send(d);
        end
        end_test("alu");

        send(make_op(exu_pkg::ALU_ADD, 4'd1, 4'd0, 4'd0, 32'd5, 1'b1));
        send(make_op(exu_pkg::ALU_ADD, 4'd2, 4'd1, 4'd1, 32'd0, 1'b0));
        send(make_op(exu_pkg::ALU_ADD, 4'd3, 4'd0, 4'd0, 32'h11, 1'b1));
        send(make_op(exu_pkg::ALU_ADD, 4'd3, 4'd0, 4'd0, 32'h22, 1'b1));
        send(make_op(exu_pkg::ALU_SUB, 4'd4, 4'd3, 4'd2, 32'd0, 1'b0));
        send(make_op(exu_pkg::ALU_ADD, 4'd0, 4'd0, 4'd0, 32'h77, 1'b1));
        send(make_op(exu_pkg::ALU_OR, 4'd5, 4'd0, 4'd0, 32'd0, 1'b0));
        end_test("forwarding");

        d = make_op(exu_pkg::ALU_ADD, 4'd6, 4'd1, 4'd0, 32'h40, 1'b1);
        d.load_size = exu_pkg::MEM_WORD;
        send(d);
        regs[6] = 32'hcafe_0123;
        fork
            send(make_op(exu_pkg::ALU_ADD, 4'd7, 4'd6, 4'd0, 32'd1, 1'b1));
            begin
                repeat (3) begin
                    @(negedge clk);
                    check("exu_ready", {31'd0, exu_ready}, 32'd0);
                end
                load_done = 1'b1;
                load_data = 32'hcafe_0123;
                @(negedge clk);
                load_done = 1'b0;
            end
        join
        end_test("load");

        d = make_op(exu_pkg::ALU_JUMP, 4'd8, 4'd0, 4'd0, 32'h40, 1'b1);
        d.src1_is_pc = 1'b1;
        d.is_jump = 1'b1;
        send(d);
        d = make_op(exu_pkg::ALU_ADD, 4'd9, 4'd0, 4'd0, 32'd3, 1'b1);
        d.is_fence_i = 1'b1;
        send(d);
        update_pc();
        send(make_op(exu_pkg::ALU_ADD, 4'd5, 4'd0, 4'd0, 32'd7, 1'b1));
        send(make_op(exu_pkg::ALU_ADD, 4'd6, 4'd0, 4'd0, 32'd7, 1'b1));
        d = make_op(exu_pkg::ALU_BEQ, 4'd0, 4'd5, 4'd6, -32'sd16, 1'b1);
        d.src1_is_pc = 1'b1;
        d.is_branch = 1'b1;
        d.gpr_we = 1'b0;
        send(d);
        update_pc();
        d.alu_op = exu_pkg::ALU_BNE;
        send(d);
        d = make_op(exu_pkg::ALU_JUMP, 4'd8, 4'd0, 4'd0, 32'd4, 1'b1);
        d.src1_is_pc = 1'b1;
        d.is_jump = 1'b1;
        send(d);
        d = '0;
        d.is_fence_i = 1'b1;
        send(d);
        end_test("redirect");

        send(make_op(exu_pkg::ALU_ADD, 4'd7, 4'd0, 4'd0, 32'h100, 1'b1));
        d = make_op(exu_pkg::ALU_ADD, 4'd1, 4'd7, 4'd0, 32'd0, 1'b0);
        d.csr_addr = exu_pkg::MTVEC;
        d.csr_rw = 1'b1;
        send(d);
        d.rs1 = 4'd0;
        d.csr_rw = 1'b0;
        d.csr_rs = 1'b1;
        send(d);
        d.rs1 = 4'd5;
        d.csr_addr = exu_pkg::MSTATUS;
        send(d);
        d.rs1 = 4'd0;
        send(d);
        d = '0;
        d.ecall = 1'b1;
        d.csr_addr = exu_pkg::MTVEC;
        send(d);
        update_pc();
        d = make_op(exu_pkg::ALU_ADD, 4'd2, 4'd0, 4'd0, 32'd0, 1'b0);
        d.csr_rs = 1'b1;
        d.csr_addr = exu_pkg::MEPC;
        send(d);
        d.csr_addr = exu_pkg::MCAUSE;
        send(d);
        d = '0;
        d.mret = 1'b1;
        d.csr_addr = exu_pkg::MEPC;
        send(d);
        update_pc();
        end_test("csr");

        send(make_op(exu_pkg::ALU_XOR, 4'd3, 4'd0, 4'd0, 32'h3c, 1'b1));
        lsu_ready = 1'b0;
        snap_valid = exe_valid;
        snap_res = exe_out.result;
        fork
            send(make_op(exu_pkg::ALU_ADD, 4'd4, 4'd3, 4'd0, 32'd1, 1'b1));
            begin
                repeat (4) begin
                    @(negedge clk);
                    check("exu_ready", {31'd0, exu_ready}, 32'd0);
                    check("exe_valid", {31'd0, exe_valid}, {31'd0, snap_valid});
                    check("exe_out.result", exe_out.result, snap_res);
                end
                lsu_ready = 1'b1;
            end
        join
        end_test("stall");

        repeat (2) @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("Some sent instructions never produced a result");
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- testbench/exu_assertions.sv
`timescale 1ns/1ns

module exu_assertions (
    input logic clk,
    input logic rst,
    input logic dec_valid,
    input logic exu_ready,
    input logic lsu_ready,
    input logic exe_valid,
    input logic redirect_valid,
    input logic pc_update
);

    // Output valid only follows an accepted instruction
    valid_after_accept: assert property (@(posedge clk) disable iff (rst)
        $rose(exe_valid) |-> $past(dec_valid && exu_ready))
        else $error("exe_valid rose without an acceptance");

    redirect_held: assert property (@(posedge clk) disable iff (rst)
        redirect_valid && !pc_update |=> redirect_valid)
        else $error("redirect_valid dropped before pc_update");

    ready_needs_lsu: assert property (@(posedge clk) disable iff (rst)
        !lsu_ready |-> !exu_ready)
        else $error("exu_ready high while lsu_ready low");

endmodule

bind exu_top exu_assertions u_assertions (
    .clk           (clk),
    .rst           (rst),
    .dec_valid     (dec_valid),
    .exu_ready     (exu_ready),
    .lsu_ready     (lsu_ready),
    .exe_valid     (exe_valid),
    .redirect_valid(redirect_valid),
    .pc_update     (pc_update)
);

//--- hw/exu_top.sv
`timescale 1ns/1ns

module exu_top #(
    parameter int BYPASS_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dec_valid,
    input  exu_pkg::dec_to_exe_t dec,
    input  logic                 lsu_ready,
    input  logic                 load_done,
    input  exu_pkg::xlen_t       load_data,
    input  logic                 pc_update,
    output logic                 exu_ready,
    output logic                 exe_valid,
    output exu_pkg::exe_to_mem_t exe_out,
    output logic                 fence_i,
    output logic                 redirect_valid,
    output exu_pkg::xlen_t       redirect_pc
);

    exu_pkg::xlen_t csr_rdata;

    exu_stage #(
        .BYPASS_DEPTH(BYPASS_DEPTH)
    ) u_stage (
        .clk           (clk),
        .rst           (rst),
        .dec_valid     (dec_valid),
        .dec           (dec),
        .lsu_ready     (lsu_ready),
        .load_done     (load_done),
        .load_data     (load_data),
        .csr_rdata     (csr_rdata),
        .pc_update     (pc_update),
        .exu_ready     (exu_ready),
        .exe_valid     (exe_valid),
        .exe_out       (exe_out),
        .fence_i       (fence_i),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc)
    );

    exu_csr u_csr (
        .clk    (clk),
        .rst    (rst),
        .rd_addr(dec.csr_addr),
        .csr_wr (exe_out.csr_wr),
        .rd_data(csr_rdata)
    );

endmodule

//--- hw/exu_csr.sv
`timescale 1ns/1ns

module exu_csr (
    input  logic                clk,
    input  logic                rst,
    input  exu_pkg::csr_addr_t  rd_addr,
    input  exu_pkg::csr_wr_t    csr_wr,
    output exu_pkg::xlen_t      rd_data
);

    exu_pkg::xlen_t mstatus;
    exu_pkg::xlen_t mtvec;
    exu_pkg::xlen_t mepc;
    exu_pkg::xlen_t mcause;

    always_comb begin
        case (rd_addr)
            exu_pkg::MSTATUS: rd_data = mstatus;
            exu_pkg::MTVEC:   rd_data = mtvec;
            exu_pkg::MEPC:    rd_data = mepc;
            exu_pkg::MCAUSE:  rd_data = mcause;
            default:          rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus <= '0;
            mtvec <= '0;
            mepc <= '0;
            mcause <= '0;
        end else begin
            if (csr_wr.en) begin
                case (csr_wr.addr)
                    exu_pkg::MSTATUS: mstatus <= csr_wr.data;
                    exu_pkg::MTVEC:   mtvec <= csr_wr.data;
                    exu_pkg::MEPC:    mepc <= csr_wr.data;
                    exu_pkg::MCAUSE:  mcause <= csr_wr.data;
                    default: ;
                endcase
            end
            // Trap entry wins over a plain write
            if (csr_wr.trap) begin
                mepc <= csr_wr.trap_pc;
                mcause <= exu_pkg::CAUSE_ECALL_M;
            end
        end
    end

endmodule

//--- hw/exu_stage.sv
`timescale 1ns/1ns

module exu_stage #(
    parameter int BYPASS_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dec_valid,
    input  exu_pkg::dec_to_exe_t dec,
    input  logic                 lsu_ready,
    input  logic                 load_done,
    input  exu_pkg::xlen_t       load_data,
    input  exu_pkg::xlen_t       csr_rdata,
    input  logic                 pc_update,
    output logic                 exu_ready,
    output logic                 exe_valid,
    output exu_pkg::exe_to_mem_t exe_out,
    output logic                 fence_i,
    output logic                 redirect_valid,
    output exu_pkg::xlen_t       redirect_pc
);

    exu_pkg::xlen_t src1;
    exu_pkg::xlen_t src2;
    exu_pkg::xlen_t alu_a;
    exu_pkg::xlen_t alu_b;
    exu_pkg::xlen_t alu_result;
    exu_pkg::xlen_t csr_old;
    exu_pkg::xlen_t csr_wdata;
    exu_pkg::xlen_t wb_data;
    exu_pkg::xlen_t pc_plus4;
    exu_pkg::xlen_t target;
    exu_pkg::exe_to_mem_t out_next;
    logic wait_src;
    logic cond;
    logic accept;
    logic live;
    logic is_csr;
    logic take;

    assign exu_ready = lsu_ready && !wait_src;
    assign accept = dec_valid && exu_ready;
    // Accepted but squashed while a redirect is outstanding
    assign live = accept && !redirect_valid;

    assign is_csr = dec.csr_rw | dec.csr_rs;

    exu_bypass #(
        .BYPASS_DEPTH(BYPASS_DEPTH)
    ) u_bypass (
        .clk         (clk),
        .rst         (rst),
        .push        (live && dec.gpr_we),
        .push_rd     (dec.rd),
        .push_data   (wb_data),
        .push_is_load(|dec.load_size),
        .load_done   (load_done),
        .load_data   (load_data),
        .rs1         (dec.rs1),
        .rs2         (dec.rs2),
        .src1_r      (dec.src1_r),
        .src2_r      (dec.src2_r),
        .src1        (src1),
        .src2        (src2),
        .wait_src    (wait_src)
    );

    assign alu_a = dec.src1_is_pc ? dec.pc : src1;
    assign alu_b = dec.src2_is_imm ? dec.imm : src2;

    exu_alu u_alu (
        .op    (dec.alu_op),
        .a     (alu_a),
        .b     (alu_b),
        .cmp_a (src1),
        .cmp_b (src2),
        .result(alu_result),
        .cond  (cond)
    );

    // CSR write still sitting in the output register has not reached the file yet
    assign csr_old = (exe_valid && exe_out.csr_wr.en && exe_out.csr_wr.addr == dec.csr_addr)
                   ? exe_out.csr_wr.data : csr_rdata;

    assign csr_wdata = ({32{dec.csr_rw}} & src1)
                     | ({32{dec.csr_rs}} & (src1 | csr_old));

    assign pc_plus4 = dec.pc + 32'd4;
    assign target = (dec.ecall | dec.mret) ? csr_old : alu_result;
    assign take = dec.ecall | dec.mret | ((dec.is_jump | dec.is_branch) & cond);

    assign wb_data = dec.is_jump ? pc_plus4 :
                     is_csr      ? csr_old  : alu_result;

    always_comb begin
        out_next.pc = dec.pc;
        out_next.rd = dec.rd;
        out_next.gpr_we = dec.gpr_we;
        out_next.load_size = dec.load_size;
        out_next.store_size = dec.store_size;
        out_next.result = wb_data;
        out_next.store_data = src2;
        out_next.csr_wr.en = live && is_csr;
        out_next.csr_wr.addr = dec.csr_addr;
        out_next.csr_wr.data = csr_wdata;
        out_next.csr_wr.trap = live && dec.ecall;
        out_next.csr_wr.trap_pc = dec.pc;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exe_valid <= 1'b0;
            exe_out <= '0;
            fence_i <= 1'b0;
        end else begin
            fence_i <= live && dec.is_fence_i;
            // Hold the bundle while the memory stage stalls
            if (lsu_ready) begin
                exe_valid <= live;
                exe_out <= out_next;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
            redirect_pc <= '0;
        end else if (!redirect_valid) begin
            if (accept && take && target != pc_plus4) begin
                redirect_valid <= 1'b1;
                redirect_pc <= target;
            end
        end else if (pc_update) begin
            redirect_valid <= 1'b0;
        end
    end

endmodule

//--- hw/exu_bypass.sv
`timescale 1ns/1ns

module exu_bypass #(
    parameter int BYPASS_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  exu_pkg::reg_idx_t push_rd,
    input  exu_pkg::xlen_t    push_data,
    input  logic              push_is_load,
    input  logic              load_done,
    input  exu_pkg::xlen_t    load_data,
    input  exu_pkg::reg_idx_t rs1,
    input  exu_pkg::reg_idx_t rs2,
    input  exu_pkg::xlen_t    src1_r,
    input  exu_pkg::xlen_t    src2_r,
    output exu_pkg::xlen_t    src1,
    output exu_pkg::xlen_t    src2,
    output logic              wait_src
);

    typedef struct packed {
        exu_pkg::reg_idx_t rd;
        exu_pkg::xlen_t data;
        logic pending;
    } entry_t;

    typedef struct packed {
        exu_pkg::xlen_t data;
        logic pending;
    } pick_t;

    // Entry 0 is the newest write
    entry_t queue [BYPASS_DEPTH];
    entry_t filled [BYPASS_DEPTH];
    entry_t new_entry;
    pick_t pick1;
    pick_t pick2;

    // Walk oldest to newest so the newest match is left standing
    function automatic pick_t lookup(exu_pkg::reg_idx_t rs, exu_pkg::xlen_t reg_val);
        pick_t sel;
        sel.data = reg_val;
        sel.pending = 1'b0;
        for (int i = BYPASS_DEPTH - 1; i >= 0; i--) begin
            if (queue[i].rd == rs && rs != '0) begin
                sel.data = queue[i].data;
                sel.pending = queue[i].pending;
            end
        end
        return sel;
    endfunction

    assign pick1 = lookup(rs1, src1_r);
    assign pick2 = lookup(rs2, src2_r);

    assign src1 = pick1.data;
    assign src2 = pick2.data;
    assign wait_src = pick1.pending | pick2.pending;

    // A returning load completes every entry still waiting on it
    always_comb begin
        for (int i = 0; i < BYPASS_DEPTH; i++) begin
            filled[i] = queue[i];
            if (load_done && queue[i].pending) begin
                filled[i].data = load_data;
                filled[i].pending = 1'b0;
            end
        end
    end

    assign new_entry.rd = push_rd;
    assign new_entry.data = push_data;
    assign new_entry.pending = push_is_load;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BYPASS_DEPTH; i++) begin
                queue[i] <= '0;
            end
        end else if (push) begin
            queue[0] <= new_entry;
            for (int i = 1; i < BYPASS_DEPTH; i++) begin
                queue[i] <= filled[i-1];
            end
        end else begin
            for (int i = 0; i < BYPASS_DEPTH; i++) begin
                queue[i] <= filled[i];
            end
        end
    end

endmodule

//--- hw/exu_alu.sv
`timescale 1ns/1ns

module exu_alu (
    input  exu_pkg::alu_op_e op,
    input  exu_pkg::xlen_t   a,
    input  exu_pkg::xlen_t   b,
    input  exu_pkg::xlen_t   cmp_a,
    input  exu_pkg::xlen_t   cmp_b,
    output exu_pkg::xlen_t   result,
    output logic             cond
);

    exu_pkg::xlen_t sum;
    logic [4:0] shamt;
    logic eq;
    logic lt_s;
    logic lt_u;

    assign sum = a + b;
    assign shamt = b[4:0];

    assign eq = (cmp_a == cmp_b);
    assign lt_s = ($signed(cmp_a) < $signed(cmp_b));
    assign lt_u = (cmp_a < cmp_b);

    always_comb begin
        case (op)
            exu_pkg::ALU_ADD:    result = sum;
            exu_pkg::ALU_SUB:    result = a - b;
            exu_pkg::ALU_AND:    result = a & b;
            exu_pkg::ALU_OR:     result = a | b;
            exu_pkg::ALU_XOR:    result = a ^ b;
            exu_pkg::ALU_SLL:    result = a << shamt;
            exu_pkg::ALU_SRL:    result = a >> shamt;
            exu_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
            exu_pkg::ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};
            exu_pkg::ALU_SLTU:   result = {31'd0, a < b};
            exu_pkg::ALU_PASS_B: result = b;
            // jalr drops the low target bit
            exu_pkg::ALU_JUMP:   result = sum & ~32'd1;
            default:             result = sum;
        endcase
    end

    always_comb begin
        case (op)
            exu_pkg::ALU_BEQ:  cond = eq;
            exu_pkg::ALU_BNE:  cond = !eq;
            exu_pkg::ALU_BLT:  cond = lt_s;
            exu_pkg::ALU_BGE:  cond = !lt_s;
            exu_pkg::ALU_BLTU: cond = lt_u;
            exu_pkg::ALU_BGEU: cond = !lt_u;
            exu_pkg::ALU_JUMP: cond = 1'b1;
            default:           cond = 1'b0;
        endcase
    end

endmodule

//--- hw/exu_pkg.sv
package exu_pkg;

    localparam int XLEN = 32;
    localparam int REG_IDX_W = 4;
    localparam int CSR_ADDR_W = 12;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // One-hot access size {word, half, byte} and zero when no access
    typedef logic [2:0] mem_size_t;

    localparam mem_size_t MEM_WORD = 3'b100;
    localparam mem_size_t MEM_HALF = 3'b010;
    localparam mem_size_t MEM_BYTE = 3'b001;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_PASS_B,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_JUMP
    } alu_op_e;

    localparam csr_addr_t MSTATUS = 12'h300;
    localparam csr_addr_t MTVEC = 12'h305;
    localparam csr_addr_t MEPC = 12'h341;
    localparam csr_addr_t MCAUSE = 12'h342;

    // Environment call from M-mode
    localparam xlen_t CAUSE_ECALL_M = 32'd11;

    typedef struct packed {
        xlen_t pc;
        xlen_t imm;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t src1_r;
        xlen_t src2_r;
        logic gpr_we;
        alu_op_e alu_op;
        logic src1_is_pc;
        logic src2_is_imm;
        logic is_jump;
        logic is_branch;
        mem_size_t load_size;
        mem_size_t store_size;
        logic is_fence_i;
        logic ecall;
        logic mret;
        csr_addr_t csr_addr;
        logic csr_rw;
        logic csr_rs;
    } dec_to_exe_t;

    typedef struct packed {
        logic en;
        csr_addr_t addr;
        xlen_t data;
        logic trap;
        xlen_t trap_pc;
    } csr_wr_t;

    typedef struct packed {
        xlen_t pc;
        reg_idx_t rd;
        logic gpr_we;
        mem_size_t load_size;
        mem_size_t store_size;
        xlen_t result;
        xlen_t store_data;
        csr_wr_t csr_wr;
    } exe_to_mem_t;

endpackage
